// ==== riscv_v_macros.svh ====
// Widths and APB register map of the vector bitwise-logic lane
`ifndef RISCV_V_MACROS_SVH
`define RISCV_V_MACROS_SVH

// Datapath geometry
`define RISCV_V_NUM_BYTES_DATA 8
`define RISCV_V_BYTE_WIDTH 8
// Fold stages of the reduction tree, log2 of the byte count
`define RISCV_V_FOLD_STAGES 3

// APB bus widths
`define RISCV_V_APB_ADDR_WIDTH 8
`define RISCV_V_APB_DATA_WIDTH 32

// Register byte offsets
`define RISCV_V_REG_SRCA_LO 8'h00
`define RISCV_V_REG_SRCA_HI 8'h04
`define RISCV_V_REG_SRCB_LO 8'h08
`define RISCV_V_REG_SRCB_HI 8'h0C
`define RISCV_V_REG_VALID 8'h10
`define RISCV_V_REG_CTRL 8'h14
`define RISCV_V_REG_STATUS 8'h18
`define RISCV_V_REG_RES_LO 8'h1C
`define RISCV_V_REG_RES_HI 8'h20

`endif

// ==== riscv_v_pkg.sv ====
// Shared types of the vector bitwise-logic lane
// Also holds the fold-tree stage select used by the three bitwise units
`default_nettype none
`include "riscv_v_macros.svh"

package riscv_v_pkg;

    // One entry per byte block
    typedef logic [`RISCV_V_BYTE_WIDTH-1:0] riscv_v_src_byte_vector_t [`RISCV_V_NUM_BYTES_DATA];

    // One valid bit per byte block
    typedef logic [`RISCV_V_NUM_BYTES_DATA-1:0] riscv_v_valid_t;

    typedef enum logic [1:0] {
        BW_AND = 2'd0,
        BW_OR  = 2'd1,
        BW_XOR = 2'd2
    } riscv_v_bw_op_t;

    // Bit k set when the element is smaller than a span of 2^(k+1) bytes
    typedef logic [`RISCV_V_FOLD_STAGES-1:0] osize_vector_t;

    // Element width code, element size is 2^sew bytes
    typedef logic [1:0] riscv_v_sew_t;

    // Fold select for one block and one tree stage
    // Block blk takes blk + 2^stage when bit stage of blk is clear
    // and every lower set bit of blk lies inside the element
    function automatic logic fold_sel(input int blk, input int stage, input osize_vector_t osize);
        logic sel;
        sel = osize[stage] & ~blk[stage];
        for (int j = 0; j < stage; j++) begin
            if (blk[j]) begin
                sel = sel & ~osize[j];
            end
        end
        return sel;
    endfunction

endpackage : riscv_v_pkg

`default_nettype wire

// ==== riscv_v_apb_regs.sv ====
// APB register block of the vector bitwise-logic lane
// Holds operands, valid masks and control, launches operations, returns results
`default_nettype none
`include "riscv_v_macros.svh"

module riscv_v_apb_regs (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [`RISCV_V_APB_ADDR_WIDTH-1:0]     paddr,
    input  logic [`RISCV_V_APB_DATA_WIDTH-1:0]     pwdata,
    output logic [`RISCV_V_APB_DATA_WIDTH-1:0]     prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    output riscv_v_pkg::riscv_v_src_byte_vector_t  srca,
    output riscv_v_pkg::riscv_v_src_byte_vector_t  srcb,
    output riscv_v_pkg::riscv_v_valid_t            srca_valid,
    output riscv_v_pkg::riscv_v_valid_t            srcb_valid,
    output riscv_v_pkg::riscv_v_bw_op_t            op,
    output logic                                   is_reduct,
    output riscv_v_pkg::riscv_v_sew_t              sew,
    output logic                                   start,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t  result,
    input  logic                                   done
);
    import riscv_v_pkg::*;

    localparam int NB = `RISCV_V_NUM_BYTES_DATA;
    localparam int W  = `RISCV_V_BYTE_WIDTH;

    // Operand, mask and control registers
    logic [NB*W-1:0] srca_q;
    logic [NB*W-1:0] srcb_q;
    logic [2*NB-1:0] valid_q;
    logic [1:0]      op_q;
    logic            reduct_q;
    logic [1:0]      sew_q;
    // Sticky done flag seen in STATUS
    logic            status_q;

    logic            wr_en;
    logic            addr_hit;

    // Zero wait states
    assign pready = 1'b1;

    assign wr_en = psel & penable & pwrite;
    // Launch in the access cycle of a CTRL write
    assign start = wr_en & (paddr == `RISCV_V_REG_CTRL);

    always_ff @(posedge clk) begin
        if (reset) begin
            srca_q   <= '0;
            srcb_q   <= '0;
            valid_q  <= '0;
            op_q     <= '0;
            reduct_q <= 1'b0;
            sew_q    <= '0;
        end else if (wr_en) begin
            // Writes to STATUS and RES fall through and are ignored
            case (paddr)
                `RISCV_V_REG_SRCA_LO: srca_q[31:0]  <= pwdata;
                `RISCV_V_REG_SRCA_HI: srca_q[63:32] <= pwdata;
                `RISCV_V_REG_SRCB_LO: srcb_q[31:0]  <= pwdata;
                `RISCV_V_REG_SRCB_HI: srcb_q[63:32] <= pwdata;
                `RISCV_V_REG_VALID:   valid_q       <= pwdata[2*NB-1:0];
                `RISCV_V_REG_CTRL: begin
                    op_q     <= pwdata[1:0];
                    reduct_q <= pwdata[2];
                    sew_q    <= pwdata[5:4];
                end
                default: ;
            endcase
        end
    end

    // New CTRL write clears, done pulse sets
    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= 1'b0;
        end else if (start) begin
            status_q <= 1'b0;
        end else if (done) begin
            status_q <= 1'b1;
        end
    end

    // Control forwarded from pwdata while the CTRL write is in flight
    assign op        = riscv_v_bw_op_t'(start ? pwdata[1:0] : op_q);
    assign is_reduct = start ? pwdata[2] : reduct_q;
    assign sew       = start ? pwdata[5:4] : sew_q;

    assign srca_valid = valid_q[NB-1:0];
    assign srcb_valid = valid_q[2*NB-1:NB];

    for (genvar i = 0; i < NB; i++) begin : gen_operands
        assign srca[i] = srca_q[i*W +: W];
        assign srcb[i] = srcb_q[i*W +: W];
    end

    // Read mux and offset decode
    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            `RISCV_V_REG_SRCA_LO: prdata = srca_q[31:0];
            `RISCV_V_REG_SRCA_HI: prdata = srca_q[63:32];
            `RISCV_V_REG_SRCB_LO: prdata = srcb_q[31:0];
            `RISCV_V_REG_SRCB_HI: prdata = srcb_q[63:32];
            `RISCV_V_REG_VALID:   prdata = {16'h0, valid_q};
            `RISCV_V_REG_CTRL:    prdata = {26'h0, sew_q, 1'b0, reduct_q, op_q};
            `RISCV_V_REG_STATUS:  prdata = {31'h0, status_q};
            `RISCV_V_REG_RES_LO:  prdata = {result[3], result[2], result[1], result[0]};
            `RISCV_V_REG_RES_HI:  prdata = {result[7], result[6], result[5], result[4]};
            default:              addr_hit = 1'b0;
        endcase
    end

    // Error only in the access phase of an unmapped offset
    assign pslverr = psel & penable & ~addr_hit;

endmodule : riscv_v_apb_regs

`default_nettype wire

// ==== riscv_v_bw_and.sv ====
// Byte-block AND unit
// Element-wise AND of two sources or a log-depth AND fold for vredand
`default_nettype none
`include "riscv_v_macros.svh"

module riscv_v_bw_and (
    input  logic                                        is_reduct,
    input  logic                                        is_op,
    input  riscv_v_pkg::osize_vector_t                  osize_vector,
    input  logic [`RISCV_V_FOLD_STAGES:0]               is_greater_osize_vector,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t       srca,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t       srcb,
    input  riscv_v_pkg::riscv_v_valid_t                 srcb_valid,
    output riscv_v_pkg::riscv_v_src_byte_vector_t       result
);
    import riscv_v_pkg::*;

    localparam int NB = `RISCV_V_NUM_BYTES_DATA;
    localparam int W  = `RISCV_V_BYTE_WIDTH;

    // Block inputs, all ones stands in for any unused byte
    logic [W-1:0] srca_bw [NB];
    logic [W-1:0] srcb_bw [NB];
    // Upper half is fixed at all ones, fold reads past the top land there
    logic [W-1:0] result_ext [2*NB];

    for (genvar blk = 0; blk < NB; blk++) begin : gen_block
        logic use_srca;

        // srca only reaches blocks inside element 0 in a reduction
        assign use_srca = ~is_reduct | is_greater_osize_vector[$clog2(blk+1)];
        assign srcb_bw[blk] = srcb[blk] | ~{W{is_op & srcb_valid[blk]}};

        always_comb begin
            srca_bw[blk] = srca[blk] | ~{W{is_op & use_srca}};
            // Pull in partial results of higher blocks
            for (int k = 0; k < `RISCV_V_FOLD_STAGES; k++) begin
                srca_bw[blk] &= result_ext[blk+(2**k)]
                              | ~{W{is_reduct & fold_sel(blk, k, osize_vector)}};
            end
        end

        assign result_ext[blk]    = srca_bw[blk] & srcb_bw[blk];
        assign result_ext[blk+NB] = '1;
        // Idle unit must not disturb the OR of the three units
        assign result[blk] = result_ext[blk] & {W{is_op}};
    end

endmodule : riscv_v_bw_and

`default_nettype wire

// ==== riscv_v_bw_or.sv ====
// Byte-block OR unit
// Element-wise OR of two sources or a log-depth OR fold for vredor
`default_nettype none
`include "riscv_v_macros.svh"

module riscv_v_bw_or (
    input  logic                                        is_reduct,
    input  logic                                        is_op,
    input  riscv_v_pkg::osize_vector_t                  osize_vector,
    input  logic [`RISCV_V_FOLD_STAGES:0]               is_greater_osize_vector,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t       srca,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t       srcb,
    input  riscv_v_pkg::riscv_v_valid_t                 srcb_valid,
    output riscv_v_pkg::riscv_v_src_byte_vector_t       result
);
    import riscv_v_pkg::*;

    localparam int NB = `RISCV_V_NUM_BYTES_DATA;
    localparam int W  = `RISCV_V_BYTE_WIDTH;

    // Block inputs after gating with is_op
    logic [W-1:0] srca_bw [NB];
    logic [W-1:0] srcb_bw [NB];
    // Upper half is tied to zero for fold reads past the top block
    logic [W-1:0] result_ext [2*NB];

    for (genvar blk = 0; blk < NB; blk++) begin : gen_block
        logic use_srca;

        // srca enters a reduction only below the element size
        assign use_srca = ~is_reduct | is_greater_osize_vector[$clog2(blk+1)];
        // Invalid srcb bytes enter as zero
        assign srcb_bw[blk] = srcb[blk] & {W{is_op & srcb_valid[blk]}};

        always_comb begin
            srca_bw[blk] = srca[blk] & {W{is_op & use_srca}};
            for (int k = 0; k < `RISCV_V_FOLD_STAGES; k++) begin
                srca_bw[blk] |= result_ext[blk+(2**k)]
                              & {W{is_reduct & fold_sel(blk, k, osize_vector)}};
            end
        end

        // Single OR per byte block
        assign result_ext[blk]    = srca_bw[blk] | srcb_bw[blk];
        assign result_ext[blk+NB] = '0;
        assign result[blk]        = result_ext[blk];
    end

endmodule : riscv_v_bw_or

`default_nettype wire

// ==== riscv_v_bw_xor.sv ====
// Byte-block XOR unit
// Element-wise XOR of two sources or a log-depth XOR fold for vredxor
`default_nettype none
`include "riscv_v_macros.svh"

module riscv_v_bw_xor (
    input  logic                                        is_reduct,
    input  logic                                        is_op,
    input  riscv_v_pkg::osize_vector_t                  osize_vector,
    input  logic [`RISCV_V_FOLD_STAGES:0]               is_greater_osize_vector,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t       srca,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t       srcb,
    input  riscv_v_pkg::riscv_v_valid_t                 srcb_valid,
    output riscv_v_pkg::riscv_v_src_byte_vector_t       result
);
    import riscv_v_pkg::*;

    localparam int NB = `RISCV_V_NUM_BYTES_DATA;
    localparam int W  = `RISCV_V_BYTE_WIDTH;

    logic [W-1:0] srca_bw [NB];
    logic [W-1:0] srcb_bw [NB];
    // Zero pad above the top block keeps every fold index in range
    logic [W-1:0] result_ext [2*NB];

    for (genvar blk = 0; blk < NB; blk++) begin : gen_block
        logic use_srca;

        assign use_srca = ~is_reduct | is_greater_osize_vector[$clog2(blk+1)];
        // Zero is the XOR identity for invalid bytes
        assign srcb_bw[blk] = srcb[blk] & {W{is_op & srcb_valid[blk]}};

        always_comb begin
            srca_bw[blk] = srca[blk] & {W{is_op & use_srca}};
            // Strict tree, each higher block is counted exactly once
            for (int k = 0; k < `RISCV_V_FOLD_STAGES; k++) begin
                srca_bw[blk] ^= result_ext[blk+(2**k)]
                              & {W{is_reduct & fold_sel(blk, k, osize_vector)}};
            end
        end

        assign result_ext[blk]    = srca_bw[blk] ^ srcb_bw[blk];
        assign result_ext[blk+NB] = '0;
        assign result[blk]        = result_ext[blk];
    end

endmodule : riscv_v_bw_xor

`default_nettype wire

// ==== riscv_v_bw_unit.sv ====
// Bitwise logic unit of the vector ALU lane
// Decodes op and SEW, merges the AND, OR and XOR units, masks and registers the result
`default_nettype none
`include "riscv_v_macros.svh"

module riscv_v_bw_unit (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  start,
    input  riscv_v_pkg::riscv_v_bw_op_t           op,
    input  logic                                  is_reduct,
    input  riscv_v_pkg::riscv_v_sew_t             sew,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srca,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srcb,
    input  riscv_v_pkg::riscv_v_valid_t           srca_valid,
    input  riscv_v_pkg::riscv_v_valid_t           srcb_valid,
    output riscv_v_pkg::riscv_v_src_byte_vector_t result,
    output logic                                  done
);
    import riscv_v_pkg::*;

    localparam int NB = `RISCV_V_NUM_BYTES_DATA;
    localparam int W  = `RISCV_V_BYTE_WIDTH;

    logic                           is_and;
    logic                           is_or;
    logic                           is_xor;
    osize_vector_t                  osize_vector;
    // Bit m set when the element spans at least 2^m bytes
    logic [`RISCV_V_FOLD_STAGES:0]  is_greater_osize_vector;
    riscv_v_src_byte_vector_t       res_and;
    riscv_v_src_byte_vector_t       res_or;
    riscv_v_src_byte_vector_t       res_xor;
    riscv_v_src_byte_vector_t       result_d;

    // One-hot unit enables, unused code enables none
    assign is_and = (op == BW_AND);
    assign is_or  = (op == BW_OR);
    assign is_xor = (op == BW_XOR);

    // SEW to fold stage enables
    always_comb begin
        for (int k = 0; k < `RISCV_V_FOLD_STAGES; k++) begin
            osize_vector[k] = (int'(sew) <= k);
        end
        for (int m = 0; m <= `RISCV_V_FOLD_STAGES; m++) begin
            is_greater_osize_vector[m] = (int'(sew) >= m);
        end
    end

    riscv_v_bw_and i_bw_and (
        .is_reduct               (is_reduct),
        .is_op                   (is_and),
        .osize_vector            (osize_vector),
        .is_greater_osize_vector (is_greater_osize_vector),
        .srca                    (srca),
        .srcb                    (srcb),
        .srcb_valid              (srcb_valid),
        .result                  (res_and)
    );

    riscv_v_bw_or i_bw_or (
        .is_reduct               (is_reduct),
        .is_op                   (is_or),
        .osize_vector            (osize_vector),
        .is_greater_osize_vector (is_greater_osize_vector),
        .srca                    (srca),
        .srcb                    (srcb),
        .srcb_valid              (srcb_valid),
        .result                  (res_or)
    );

    riscv_v_bw_xor i_bw_xor (
        .is_reduct               (is_reduct),
        .is_op                   (is_xor),
        .osize_vector            (osize_vector),
        .is_greater_osize_vector (is_greater_osize_vector),
        .srca                    (srca),
        .srcb                    (srcb),
        .srcb_valid              (srcb_valid),
        .result                  (res_xor)
    );

    for (genvar i = 0; i < NB; i++) begin : gen_mask
        logic keep;

        // Reduction keeps element 0 only, element-wise keeps valid srca bytes
        assign keep = is_reduct ? is_greater_osize_vector[$clog2(i+1)] : srca_valid[i];
        assign result_d[i] = (res_and[i] | res_or[i] | res_xor[i]) & {W{keep}};
    end

    // Result and done land one clock after start
    always_ff @(posedge clk) begin
        if (reset) begin
            done   <= 1'b0;
            result <= '{default: '0};
        end else begin
            done <= start;
            if (start) begin
                result <= result_d;
            end
        end
    end

endmodule : riscv_v_bw_unit

`default_nettype wire

// ==== riscv_v_bw_top.sv ====
// Top level of the vector bitwise-logic lane
// APB register block driving the bitwise logic unit
`default_nettype none
`include "riscv_v_macros.svh"

module riscv_v_bw_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [`RISCV_V_APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`RISCV_V_APB_DATA_WIDTH-1:0] pwdata,
    output logic [`RISCV_V_APB_DATA_WIDTH-1:0] prdata,
    output logic                               pready,
    output logic                               pslverr
);
    import riscv_v_pkg::*;

    // Register block to unit
    riscv_v_src_byte_vector_t srca;
    riscv_v_src_byte_vector_t srcb;
    riscv_v_valid_t           srca_valid;
    riscv_v_valid_t           srcb_valid;
    riscv_v_bw_op_t           op;
    logic                     is_reduct;
    riscv_v_sew_t             sew;
    logic                     start;
    // Unit back to register block
    riscv_v_src_byte_vector_t result;
    logic                     done;

    riscv_v_apb_regs i_apb_regs (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .srca       (srca),
        .srcb       (srcb),
        .srca_valid (srca_valid),
        .srcb_valid (srcb_valid),
        .op         (op),
        .is_reduct  (is_reduct),
        .sew        (sew),
        .start      (start),
        .result     (result),
        .done       (done)
    );

    riscv_v_bw_unit i_bw_unit (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .op         (op),
        .is_reduct  (is_reduct),
        .sew        (sew),
        .srca       (srca),
        .srcb       (srcb),
        .srca_valid (srca_valid),
        .srcb_valid (srcb_valid),
        .result     (result),
        .done       (done)
    );

endmodule : riscv_v_bw_top

`default_nettype wire

// ==== riscv_v_bw_assert.sv ====
// Bound checks for the vector bitwise-logic lane
// APB ready and error timing, done one clock after start
`default_nettype none
`include "riscv_v_macros.svh"

module riscv_v_bw_assert (
    input logic                               clk,
    input logic                               reset,
    input logic                               psel,
    input logic                               penable,
    input logic [`RISCV_V_APB_ADDR_WIDTH-1:0] paddr,
    input logic                               pready,
    input logic                               pslverr,
    input logic                               start,
    input logic                               done
);
    timeunit 1ns;
    timeprecision 1ps;

    logic mapped;

    // Offsets that decode to a register
    assign mapped = paddr inside {`RISCV_V_REG_SRCA_LO, `RISCV_V_REG_SRCA_HI,
                                  `RISCV_V_REG_SRCB_LO, `RISCV_V_REG_SRCB_HI,
                                  `RISCV_V_REG_VALID, `RISCV_V_REG_CTRL,
                                  `RISCV_V_REG_STATUS, `RISCV_V_REG_RES_LO,
                                  `RISCV_V_REG_RES_HI};

    // Zero wait states
    pready_in_access: assert property (@(posedge clk) disable iff (reset)
        (psel && penable) |-> pready)
        else $error("pready low in an APB access phase");

    done_after_start: assert property (@(posedge clk) disable iff (reset) start |=> done)
        else $error("done did not follow start on the next clock");

    pslverr_unmapped: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> (psel && penable && !mapped))
        else $error("pslverr outside an access to an unmapped offset");

endmodule : riscv_v_bw_assert

`default_nettype wire

// ==== tb_riscv_v_bw.sv ====
// Testbench for the vector bitwise-logic lane
// Random APB stimulus checked against a byte-level model of the bitwise ops and reductions
`default_nettype none
`include "riscv_v_macros.svh"

module tb_riscv_v_bw;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int POLL_LIMIT = 16;

    logic                               clk;
    logic                               reset;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic [`RISCV_V_APB_ADDR_WIDTH-1:0] paddr;
    logic [`RISCV_V_APB_DATA_WIDTH-1:0] pwdata;
    logic [`RISCV_V_APB_DATA_WIDTH-1:0] prdata;
    logic                               pready;
    logic                               pslverr;

    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     test_err_base;
    string  test_name;

    riscv_v_bw_top i_dut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    bind riscv_v_bw_top riscv_v_bw_assert i_assert (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .paddr   (paddr),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .done    (done)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("FAILED %s (%s): expected %h, actual %h", test_name, name, expected,
                     actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == test_err_base) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", test_name, errors - test_err_base);
        end
    endtask

    // Setup and access phase, then one idle cycle
    // pready and pslverr sampled in the middle of the access phase
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check_value("pready in write access", 64'd1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_value("pready in read access", 64'd1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic load_operands(input logic [63:0] a, input logic [63:0] b,
                                 input logic [7:0] va, input logic [7:0] vb);
        logic err;
        apb_write(`RISCV_V_REG_SRCA_LO, a[31:0], err);
        apb_write(`RISCV_V_REG_SRCA_HI, a[63:32], err);
        apb_write(`RISCV_V_REG_SRCB_LO, b[31:0], err);
        apb_write(`RISCV_V_REG_SRCB_HI, b[63:32], err);
        apb_write(`RISCV_V_REG_VALID, {16'h0, vb, va}, err);
    endtask

    // Poll STATUS until done is set
    // first_set is high when the very first read already saw done
    task automatic wait_done(output logic first_set);
        logic [31:0] data;
        logic        err;
        logic        set;
        int          polls;
        set   = 1'b0;
        polls = 0;
        while (!set && polls < POLL_LIMIT) begin
            apb_read(`RISCV_V_REG_STATUS, data, err);
            set = data[0];
            polls++;
        end
        first_set = set && (polls == 1);
        if (!set) begin
            $display("Timeout in %s: done bit in STATUS never set after %0d reads",
                     test_name, POLL_LIMIT);
            errors++;
        end
    endtask

    task automatic read_result(output logic [63:0] res);
        logic [31:0] lo;
        logic [31:0] hi;
        logic        err;
        apb_read(`RISCV_V_REG_RES_LO, lo, err);
        apb_read(`RISCV_V_REG_RES_HI, hi, err);
        res = {hi, lo};
    endtask

    task automatic run_op(input logic [63:0] a, input logic [63:0] b, input logic [7:0] va,
                          input logic [7:0] vb, input logic [1:0] op, input logic reduct,
                          input logic [1:0] sew, output logic [63:0] res);
        logic err;
        logic first;
        load_operands(a, b, va, vb);
        apb_write(`RISCV_V_REG_CTRL, {26'h0, sew, 1'b0, reduct, op}, err);
        wait_done(first);
        // One clock of latency leaves done visible to the first poll
        check_value("done on first poll", 64'd1, first);
        read_result(res);
    endtask

    function automatic logic [63:0] combine(input logic [63:0] x, input logic [63:0] y,
                                            input logic [1:0] op);
        case (op)
            2'd0:    return x & y;
            2'd1:    return x | y;
            default: return x ^ y;
        endcase
    endfunction

    // Reference model built from the byte rules
    function automatic logic [63:0] expected_result(input logic [63:0] a, input logic [63:0] b,
            input logic [7:0] va, input logic [7:0] vb, input logic [1:0] op,
            input logic reduct, input logic [1:0] sew);
        logic [63:0] b_eff;
        logic [63:0] el_mask;
        logic [63:0] acc;
        int          el_bits;
        // Invalid srcb bytes turn into the identity of the op
        for (int i = 0; i < 8; i++) begin
            b_eff[i*8 +: 8] = vb[i] ? b[i*8 +: 8] : ((op == 2'd0) ? 8'hff : 8'h00);
        end
        if (!reduct) begin
            acc = combine(a, b_eff, op);
            for (int i = 0; i < 8; i++) begin
                if (!va[i]) begin
                    acc[i*8 +: 8] = 8'h00;
                end
            end
            return acc;
        end
        el_bits = 8 << sew;
        el_mask = (el_bits == 64) ? '1 : ((64'd1 << el_bits) - 64'd1);
        // srca element 0 folded with every srcb element
        acc = a & el_mask;
        for (int j = 0; j < 64 / el_bits; j++) begin
            acc = combine(acc, (b_eff >> (j * el_bits)) & el_mask, op);
        end
        return acc & el_mask;
    endfunction

    initial begin
        logic [63:0] a;
        logic [63:0] b;
        logic [7:0]  va;
        logic [7:0]  vb;
        logic [1:0]  op;
        logic [1:0]  sew;
        logic [63:0] res;
        logic [63:0] res_before;
        logic [31:0] data;
        logic        err;
        logic        first;

        seed         = 32'h1389;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clk          = 1'b0;
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        start_test("reset_values");
        apb_read(`RISCV_V_REG_STATUS, data, err);
        check_value("reset STATUS", 64'd0, data);
        read_result(res);
        check_value("reset RES", 64'd0, res);
        finish_test();

        start_test("elementwise");
        for (int n = 0; n < 200; n++) begin
            a   = {$random(seed), $random(seed)};
            b   = {$random(seed), $random(seed)};
            va  = $random(seed);
            vb  = $random(seed);
            op  = 2'($unsigned($random(seed)) % 3);
            sew = $random(seed);
            run_op(a, b, va, vb, op, 1'b0, sew, res);
            check_value($sformatf("elementwise #%0d op %0d", n, op),
                        expected_result(a, b, va, vb, op, 1'b0, sew), res);
        end
        finish_test();

        start_test("reduction");
        for (int o = 0; o < 3; o++) begin
            for (int s = 0; s < 4; s++) begin
                for (int n = 0; n < 6; n++) begin
                    a  = {$random(seed), $random(seed)};
                    b  = {$random(seed), $random(seed)};
                    // Reductions ignore the random srca_valid
                    va = $random(seed);
                    vb = $random(seed);
                    run_op(a, b, va, vb, 2'(o), 1'b1, 2'(s), res);
                    check_value($sformatf("reduction op %0d sew %0d #%0d", o, s, n),
                                expected_result(a, b, va, vb, 2'(o), 1'b1, 2'(s)), res);
                end
            end
        end
        finish_test();

        start_test("done_flag");
        a  = {$random(seed), $random(seed)};
        b  = {$random(seed), $random(seed)};
        va = $random(seed);
        vb = $random(seed);
        load_operands(a, b, va, vb);
        apb_read(`RISCV_V_REG_STATUS, data, err);
        check_value("STATUS sticky", 64'd1, data[0]);
        apb_write(`RISCV_V_REG_CTRL, {26'h0, 2'd0, 1'b0, 1'b0, 2'd2}, err);
        // Peek the read mux with the bus idle before the next clock
        paddr <= `RISCV_V_REG_STATUS;
        @(negedge clk);
        check_value("STATUS cleared by CTRL write", 64'd0, prdata[0]);
        wait_done(first);
        check_value("done on first STATUS read", 64'd1, first);
        read_result(res);
        check_value("done_flag result", expected_result(a, b, va, vb, 2'd2, 1'b0, 2'd0), res);
        finish_test();

        start_test("apb_errors");
        apb_read(8'h24, data, err);
        check_value("unmapped read pslverr", 64'd1, err);
        apb_write(8'h40, $random(seed), err);
        check_value("unmapped write pslverr", 64'd1, err);
        read_result(res_before);
        apb_write(`RISCV_V_REG_RES_LO, ~res_before[31:0], err);
        check_value("RES write pslverr", 64'd0, err);
        apb_write(`RISCV_V_REG_RES_HI, ~res_before[63:32], err);
        read_result(res);
        check_value("RES unchanged by write", res_before, res);
        finish_test();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_riscv_v_bw

`default_nettype wire

// ==== riscv_v_bw.f ====
+incdir+.
riscv_v_pkg.sv
riscv_v_apb_regs.sv
riscv_v_bw_and.sv
riscv_v_bw_or.sv
riscv_v_bw_xor.sv
riscv_v_bw_unit.sv
riscv_v_bw_top.sv
riscv_v_bw_assert.sv
tb_riscv_v_bw.sv

// ==== Makefile ====
# Verilator flow for the vector bitwise-logic lane

VERILATOR  ?= verilator
TOP        := tb_riscv_v_bw
RTL_TOP    := riscv_v_bw_top
FLIST      := riscv_v_bw.f
COMMON     := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON)
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
